// ==== Bender.yml ====
package:
  name: array_conv_row_ctrl

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/conv_row_pkg.sv
      - rtl/act_row_buffer.sv
      - rtl/result_drain.sv
      - rtl/conv_row_sequencer.sv
      - rtl/array_conv_row_ctrl.sv
  - target: test
    files:
      - tb/array_conv_row_ctrl_properties.sv
      - tb/array_conv_row_ctrl_tb.sv

// ==== build.f ====
+incdir+rtl
rtl/conv_row_pkg.sv
rtl/act_row_buffer.sv
rtl/result_drain.sv
rtl/conv_row_sequencer.sv
rtl/array_conv_row_ctrl.sv
tb/array_conv_row_ctrl_properties.sv
tb/array_conv_row_ctrl_tb.sv

// ==== rtl/act_row_buffer.sv ====
`timescale 1ns/10ps
`include "conv_row_settings.svh"

module act_row_buffer (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   act_load_i,
    input  conv_row_pkg::act_t      act_load_data_i,
    input  logic                   feed_en_i,
    input  logic                   clear_i,
    input  conv_row_pkg::col_mask_t col_active_i,
    input  conv_row_pkg::col_mask_t afifo_full_i,
    output conv_row_pkg::col_mask_t afifo_write_o,
    output conv_row_pkg::act_t      afifo_data_o,
    output logic                   row_fed_o
);
    import conv_row_pkg::*;

    localparam int ADDR_W = $clog2(`CONV_ACT_DEPTH);

    // activation storage, written in load order
    act_t       act_mem [`CONV_ACT_DEPTH];
    act_count_t fill_cnt;
    act_count_t feed_idx;
    logic       fed_q;

    logic has_next;
    logic row_full;
    logic do_write;

    assign has_next = feed_idx < fill_cnt;

    // any full FIFO in the row stalls the whole row
    assign row_full = |afifo_full_i;
    assign do_write = feed_en_i && has_next && !row_full;

    // the same activation goes to every active column of the row
    assign afifo_write_o = do_write ? col_active_i : '0;
    assign afifo_data_o  = act_mem[feed_idx[ADDR_W-1:0]];

    // empty row reports fed in its first FEED cycle
    assign row_fed_o = fed_q || (feed_en_i && !has_next);

    always_ff @(posedge clk) begin
        if (act_load_i && fill_cnt < act_count_t'(`CONV_ACT_DEPTH)) begin
            act_mem[fill_cnt[ADDR_W-1:0]] <= act_load_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fill_cnt <= '0;
            feed_idx <= '0;
            fed_q    <= 1'b0;
        end else if (clear_i) begin
            fill_cnt <= '0;
            feed_idx <= '0;
            fed_q    <= 1'b0;
        end else begin
            // appends beyond the buffer depth are dropped
            if (act_load_i && fill_cnt < act_count_t'(`CONV_ACT_DEPTH)) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            // index only moves on an accepted write, so a stall re-offers it
            if (do_write) begin
                feed_idx <= feed_idx + 1'b1;
            end
            if (feed_en_i && !has_next) begin
                fed_q <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/array_conv_row_ctrl.sv ====
`timescale 1ns/10ps
`include "conv_row_settings.svh"

module array_conv_row_ctrl (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic                               act_load_i,
    input  logic [$clog2(`CONV_NUM_PE_ROW)-1:0] act_load_row_i,
    input  conv_row_pkg::act_t                  act_load_data_i,
    input  logic                               start_i,
    output logic                               done_o,
    input  conv_row_pkg::etc_col_t              wetc_i [`CONV_NUM_PE_COL],
    output conv_row_pkg::pe_mask_t              pe_start_o,
    output logic [`CONV_NUM_PE_ROW-1:0]          act_feed_done_o,
    output conv_row_pkg::pe_mask_t              afifo_write_o,
    output conv_row_pkg::act_t                  afifo_data_o [`CONV_NUM_PE_ROW],
    output conv_row_pkg::pe_mask_t              accfifo_read_o,
    output conv_row_pkg::pe_mask_t              out_to_right_en_o,
    output logic                               clr_pe_done_o,
    input  conv_row_pkg::pe_mask_t              pe_done_i,
    input  conv_row_pkg::pe_mask_t              afifo_full_i,
    input  conv_row_pkg::pe_mask_t              accfifo_empty_i
);
    import conv_row_pkg::*;

    localparam int NCOL = `CONV_NUM_PE_COL;

    col_mask_t                   col_active;
    logic [`CONV_NUM_PE_ROW-1:0] row_fed;
    logic                        feed_en;
    logic                        drain_en;
    logic                        drain_done;
    logic                        clear;

    // one buffer per PE row, each owns its slice of the PE masks
    for (genvar r = 0; r < `CONV_NUM_PE_ROW; r++) begin : g_row
        logic row_load;

        assign row_load = act_load_i && (act_load_row_i == r);

        act_row_buffer u_buf (
            .clk             (clk),
            .reset_i         (reset_i),
            .act_load_i      (row_load),
            .act_load_data_i (act_load_data_i),
            .feed_en_i       (feed_en),
            .clear_i         (clear),
            .col_active_i    (col_active),
            .afifo_full_i    (afifo_full_i[r*NCOL +: NCOL]),
            .afifo_write_o   (afifo_write_o[r*NCOL +: NCOL]),
            .afifo_data_o    (afifo_data_o[r]),
            .row_fed_o       (row_fed[r])
        );
    end

    assign act_feed_done_o = row_fed;

    result_drain u_drain (
        .clk               (clk),
        .reset_i           (reset_i),
        .drain_en_i        (drain_en),
        .pe_start_i        (pe_start_o),
        .accfifo_empty_i   (accfifo_empty_i),
        .accfifo_read_o    (accfifo_read_o),
        .out_to_right_en_o (out_to_right_en_o),
        .drain_done_o      (drain_done)
    );

    conv_row_sequencer u_seq (
        .clk           (clk),
        .reset_i       (reset_i),
        .start_i       (start_i),
        .wetc_i        (wetc_i),
        .row_fed_i     (row_fed),
        .pe_done_i     (pe_done_i),
        .drain_done_i  (drain_done),
        .col_active_o  (col_active),
        .pe_start_o    (pe_start_o),
        .feed_en_o     (feed_en),
        .drain_en_o    (drain_en),
        .clear_o       (clear),
        .clr_pe_done_o (clr_pe_done_o),
        .done_o        (done_o)
    );

endmodule

// ==== rtl/conv_row_pkg.sv ====
`include "conv_row_settings.svh"

package conv_row_pkg;

    // compressed activation, one bit wider than the raw value
    typedef logic [`CONV_ACT_WIDTH:0] act_t;

    // encoded-term counts of all taps of one weight column
    typedef logic [`CONV_ETC_WIDTH*`CONV_NB_TAPS-1:0] etc_col_t;

    // one bit per PE column
    typedef logic [`CONV_NUM_PE_COL-1:0] col_mask_t;

    // one bit per PE, row-major
    typedef logic [`CONV_NUM_PE_ROW*`CONV_NUM_PE_COL-1:0] pe_mask_t;

    // activation index or fill count, reaches CONV_ACT_DEPTH itself
    typedef logic [$clog2(`CONV_ACT_DEPTH+1)-1:0] act_count_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        FEED,
        WAIT_PE,
        DRAIN,
        CLEAR,
        FINISH
    } seq_state_t;

endpackage

// ==== rtl/conv_row_sequencer.sv ====
`timescale 1ns/10ps
`include "conv_row_settings.svh"

module conv_row_sequencer (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   start_i,
    input  conv_row_pkg::etc_col_t  wetc_i [`CONV_NUM_PE_COL],
    input  logic [`CONV_NUM_PE_ROW-1:0] row_fed_i,
    input  conv_row_pkg::pe_mask_t  pe_done_i,
    input  logic                   drain_done_i,
    output conv_row_pkg::col_mask_t col_active_o,
    output conv_row_pkg::pe_mask_t  pe_start_o,
    output logic                   feed_en_o,
    output logic                   drain_en_o,
    output logic                   clear_o,
    output logic                   clr_pe_done_o,
    output logic                   done_o
);
    import conv_row_pkg::*;

    seq_state_t state_q;
    seq_state_t state_nxt;
    col_mask_t  col_active_q;
    col_mask_t  col_active_nxt;
    pe_mask_t   pe_started;
    logic       pe_active;
    logic       all_pe_done;

    // a column with all-zero term counts has nothing to compute
    always_comb begin
        for (int c = 0; c < `CONV_NUM_PE_COL; c++) begin
            col_active_nxt[c] = |wetc_i[c];
        end
    end

    // same column mask for every PE row
    assign pe_started = {`CONV_NUM_PE_ROW{col_active_q}};

    assign pe_active = (state_q == FEED) || (state_q == WAIT_PE) ||
                       (state_q == DRAIN) || (state_q == CLEAR);

    // done flags of unstarted PEs do not matter
    assign all_pe_done = (pe_done_i & pe_started) == pe_started;

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_nxt = FEED;
                end
            end
            FEED: begin
                if (&row_fed_i) begin
                    state_nxt = WAIT_PE;
                end
            end
            WAIT_PE: begin
                if (all_pe_done) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                if (drain_done_i) begin
                    state_nxt = CLEAR;
                end
            end
            CLEAR:   state_nxt = FINISH;
            FINISH:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= IDLE;
            col_active_q <= '0;
        end else begin
            state_q <= state_nxt;
            // weights are stable for the whole run, latch once at start
            if (state_q == IDLE && start_i) begin
                col_active_q <= col_active_nxt;
            end
        end
    end

    assign col_active_o  = col_active_q;
    assign pe_start_o    = pe_active ? pe_started : '0;
    assign feed_en_o     = state_q == FEED;
    assign drain_en_o    = state_q == DRAIN;
    assign clear_o       = state_q == CLEAR;
    assign clr_pe_done_o = state_q == CLEAR;
    assign done_o        = state_q == FINISH;

endmodule

// ==== rtl/conv_row_settings.svh ====
`ifndef CONV_ROW_SETTINGS_SVH
`define CONV_ROW_SETTINGS_SVH

// PE array geometry
`define CONV_NUM_PE_ROW 2
`define CONV_NUM_PE_COL 2

// raw activation width, compressed form adds one flag bit
`define CONV_ACT_WIDTH 16

// encoded-term count per tap and taps per weight column
`define CONV_ETC_WIDTH 4
`define CONV_NB_TAPS 11

// activations held by one row buffer
`define CONV_ACT_DEPTH 16

`endif

// ==== rtl/result_drain.sv ====
`timescale 1ns/10ps

module result_drain (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  drain_en_i,
    input  conv_row_pkg::pe_mask_t pe_start_i,
    input  conv_row_pkg::pe_mask_t accfifo_empty_i,
    output conv_row_pkg::pe_mask_t accfifo_read_o,
    output conv_row_pkg::pe_mask_t out_to_right_en_o,
    output logic                  drain_done_o
);
    import conv_row_pkg::*;

    pe_mask_t rd_mask;
    pe_mask_t fwd_q;
    logic     reads_left;
    logic     fwd_pending;

    // read every started PE that still holds results
    assign rd_mask = drain_en_i ? (pe_start_i & ~accfifo_empty_i) : '0;
    assign accfifo_read_o = rd_mask;

    // accumulation data shows up one cycle after its read
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fwd_q <= '0;
        end else begin
            fwd_q <= rd_mask;
        end
    end

    assign out_to_right_en_o = fwd_q;

    assign reads_left  = |(pe_start_i & ~accfifo_empty_i);
    assign fwd_pending = |fwd_q;

    // done only once the last read has been forwarded
    assign drain_done_o = drain_en_i && !reads_left && !fwd_pending;

endmodule

// ==== tb/array_conv_row_ctrl_properties.sv ====
`timescale 1ns/10ps
`include "conv_row_settings.svh"

module array_conv_row_ctrl_properties (
    input logic                   clk,
    input logic                   reset_i,
    input logic                   done_o,
    input conv_row_pkg::pe_mask_t pe_start_o,
    input conv_row_pkg::pe_mask_t afifo_write_o,
    input conv_row_pkg::pe_mask_t afifo_full_i,
    input conv_row_pkg::pe_mask_t accfifo_read_o,
    input conv_row_pkg::pe_mask_t out_to_right_en_o
);
    import conv_row_pkg::*;

    localparam int NCOL = `CONV_NUM_PE_COL;

    pe_mask_t row_full;

    // one full FIFO blocks its whole row
    always_comb begin
        for (int r = 0; r < `CONV_NUM_PE_ROW; r++) begin
            row_full[r*NCOL +: NCOL] = {NCOL{|afifo_full_i[r*NCOL +: NCOL]}};
        end
    end

    no_write_when_full: assert property (@(posedge clk) disable iff (reset_i)
        (afifo_write_o & row_full) == '0)
        else $error("afifo write to a row that reports full");

    only_started_pes: assert property (@(posedge clk) disable iff (reset_i)
        ((afifo_write_o | accfifo_read_o) & ~pe_start_o) == '0)
        else $error("write or read to a PE that was not started");

    done_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        done_o |=> !done_o)
        else $error("done_o held for more than one cycle");

    forward_after_read: assert property (@(posedge clk) disable iff (reset_i)
        1'b1 |=> out_to_right_en_o == $past(accfifo_read_o))
        else $error("out_to_right_en_o does not follow accfifo_read_o");

endmodule

bind array_conv_row_ctrl array_conv_row_ctrl_properties u_props (
    .clk               (clk),
    .reset_i           (reset_i),
    .done_o            (done_o),
    .pe_start_o        (pe_start_o),
    .afifo_write_o     (afifo_write_o),
    .afifo_full_i      (afifo_full_i),
    .accfifo_read_o    (accfifo_read_o),
    .out_to_right_en_o (out_to_right_en_o)
);

// ==== tb/array_conv_row_ctrl_tb.sv ====
`timescale 1ns/10ps
`include "conv_row_settings.svh"

module array_conv_row_ctrl_tb;
    import conv_row_pkg::*;

    localparam int NROW = `CONV_NUM_PE_ROW;
    localparam int NCOL = `CONV_NUM_PE_COL;
    localparam int NPE = NROW * NCOL;
    localparam int NUM_SCN = 3;
    localparam int DONE_DELAY = 5;
    localparam int RUN_CYCLES = NUM_SCN * (2 * `CONV_ACT_DEPTH + 60);

    logic                    clk = 1'b0;
    logic                    reset_i;
    logic                    act_load_i;
    logic [$clog2(NROW)-1:0] act_load_row_i;
    act_t                    act_load_data_i;
    logic                    start_i;
    logic                    done_o;
    etc_col_t                wetc_i [NCOL];
    pe_mask_t                pe_start_o;
    logic [NROW-1:0]         act_feed_done_o;
    pe_mask_t                afifo_write_o;
    act_t                    afifo_data_o [NROW];
    pe_mask_t                accfifo_read_o;
    pe_mask_t                out_to_right_en_o;
    logic                    clr_pe_done_o;
    pe_mask_t                pe_done_i;
    pe_mask_t                afifo_full_i;
    pe_mask_t                accfifo_empty_i;

    // scenario table: weight columns, row lengths, first activation, acc entries, stall
    etc_col_t   scn_wetc [NUM_SCN][NCOL] = '{'{44'h321, 44'h100_0000_0000},
                                             '{44'h0, 44'h40_0000},
                                             '{44'h5, 44'h9}};
    act_count_t scn_len [NUM_SCN][NROW] = '{'{5, 3}, '{4, 6}, '{0, 7}};
    act_t       scn_base [NUM_SCN][NROW] = '{'{17'h00101, 17'h10a00},
                                             '{17'h0f0f0, 17'h1c3c3},
                                             '{17'h00000, 17'h12345}};
    int         scn_acc [NUM_SCN][NPE] = '{'{2, 1, 3, 0}, '{3, 2, 1, 2}, '{1, 1, 2, 2}};
    int         scn_full [NUM_SCN] = '{4, 3, 6};

    // PE array model state
    int              seed = 32'h3491;
    int              cur = 0;
    int              acc_left [NPE] = '{default: 0};
    int              rd_cnt [NPE];
    int              wr_idx [NROW];
    int              done_wait [NROW] = '{default: 0};
    logic [NROW-1:0] fed_seen = '0;
    pe_mask_t        pe_done_q = '0;
    pe_mask_t        read_q = '0;
    int              full_left = 0;
    logic            full_armed = 1'b0;
    int              full_row;
    int              full_col;
    int              clr_cnt;
    int              done_cnt;
    int              errors = 0;
    int              checks = 0;

    array_conv_row_ctrl UUT (.*);

    always #20 clk = ~clk;

    function automatic col_mask_t col_mask(int s);
        col_mask_t m;
        for (int c = 0; c < NCOL; c++) begin
            m[c] = scn_wetc[s][c] != '0;
        end
        return m;
    endfunction

    function automatic pe_mask_t exp_start(int s);
        return {NROW{col_mask(s)}};
    endfunction

    function automatic act_t act_value(int s, int r, int k);
        return scn_base[s][r] + act_t'(k * 'h0107);
    endfunction

    task automatic check_act(string name, act_t got, act_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(string name, pe_mask_t got, pe_mask_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(string name, act_count_t got, act_count_t exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // PE array inputs change shortly after the edge
    always @(posedge clk) begin
        pe_mask_t full_v;
        pe_mask_t empty_v;
        #2;
        full_v = '0;
        if (full_left > 0) begin
            full_v[full_row * NCOL + full_col] = 1'b1;
        end
        for (int p = 0; p < NPE; p++) begin
            empty_v[p] = acc_left[p] == 0;
        end
        afifo_full_i    = full_v;
        accfifo_empty_i = empty_v;
        pe_done_i       = pe_done_q;
    end

    // outputs are sampled mid-cycle, where they are settled
    always @(negedge clk) begin
        pe_mask_t   row_sel;
        act_count_t exp_fed;
        if (!reset_i) begin
            check_mask("out_to_right_en_o", out_to_right_en_o, read_q);
            read_q = accfifo_read_o;
            for (int p = 0; p < NPE; p++) begin
                if (accfifo_read_o[p]) begin
                    rd_cnt[p]++;
                    if (acc_left[p] > 0) acc_left[p]--;
                end
            end
            if (full_left > 0) full_left--;
            for (int r = 0; r < NROW; r++) begin
                row_sel = pe_mask_t'({NCOL{1'b1}}) << (r * NCOL);
                if ((afifo_write_o & row_sel) != '0) begin
                    check_mask("afifo_write_o", afifo_write_o & row_sel,
                               pe_mask_t'(col_mask(cur)) << (r * NCOL));
                    if (wr_idx[r] < scn_len[cur][r]) begin
                        check_act("afifo_data_o", afifo_data_o[r], act_value(cur, r, wr_idx[r]));
                    end else begin
                        $display("row %0d was written more often than it was loaded", r);
                        errors++;
                    end
                    wr_idx[r]++;
                    // first write to the chosen row starts the full stall
                    if (full_armed && r == full_row) begin
                        full_left  = scn_full[cur];
                        full_armed = 1'b0;
                    end
                end
                if (act_feed_done_o[r] && !fed_seen[r]) begin
                    fed_seen[r] = 1'b1;
                    exp_fed = (col_mask(cur) != '0) ? scn_len[cur][r] : '0;
                    check_count("activations written", act_count_t'(wr_idx[r]), exp_fed);
                end
                if (fed_seen[r] && done_wait[r] < DONE_DELAY) begin
                    done_wait[r]++;
                    if (done_wait[r] == DONE_DELAY) pe_done_q |= pe_start_o & row_sel;
                end
            end
            if (clr_pe_done_o) begin
                check_mask("pe_done_i at clear", pe_done_i & exp_start(cur), exp_start(cur));
                clr_cnt++;
                pe_done_q = '0;
                fed_seen  = '0;
                done_wait = '{default: 0};
            end
            if (done_o) begin
                done_cnt++;
                if (clr_cnt != 1) begin
                    $display("done_o came without exactly one clr_pe_done_o pulse before it");
                    errors++;
                end
            end
        end
    end

    task automatic run_scenario(int s);
        int        err_before;
        pe_mask_t  started;
        col_mask_t cols;
        err_before = errors;
        started    = exp_start(s);
        cols       = col_mask(s);
        cur        = s;
        for (int p = 0; p < NPE; p++) begin
            acc_left[p] = scn_acc[s][p];
            rd_cnt[p]   = 0;
        end
        wr_idx   = '{default: 0};
        clr_cnt  = 0;
        done_cnt = 0;
        full_row = $unsigned($random(seed)) % NROW;
        full_col = $unsigned($random(seed)) % NCOL;
        if (scn_len[s][full_row] < 2) full_row = NROW - 1 - full_row;
        if (!cols[full_col]) full_col = NCOL - 1 - full_col;
        full_armed = 1'b1;
        wetc_i = scn_wetc[s];
        for (int r = 0; r < NROW; r++) begin
            for (int k = 0; k < scn_len[s][r]; k++) begin
                @(posedge clk);
                #2;
                act_load_i      = 1'b1;
                act_load_row_i  = r;
                act_load_data_i = act_value(s, r, k);
            end
        end
        @(posedge clk);
        #2;
        act_load_i = 1'b0;
        start_i    = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        @(negedge clk);
        check_mask("pe_start_o", pe_start_o, started);
        while (!done_o) @(negedge clk);
        repeat (3) @(negedge clk);
        check_count("done_o pulses", act_count_t'(done_cnt), 1);
        for (int p = 0; p < NPE; p++) begin
            check_count("accfifo_read_o pulses", act_count_t'(rd_cnt[p]),
                        started[p] ? act_count_t'(scn_acc[s][p]) : '0);
        end
        $display("scenario %0d finished with %0d error(s)", s, errors - err_before);
    endtask

    initial begin
        reset_i         = 1'b1;
        act_load_i      = 1'b0;
        act_load_row_i  = '0;
        act_load_data_i = '0;
        start_i         = 1'b0;
        wetc_i          = '{default: '0};
        pe_done_i       = '0;
        afifo_full_i    = '0;
        accfifo_empty_i = '1;
        repeat (10) @(posedge clk);
        #2;
        reset_i = 1'b0;
        for (int s = 0; s < NUM_SCN; s++) begin
            run_scenario(s);
        end
        $display("%0d scenarios, %0d checks, %0d errors", NUM_SCN, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        #((RUN_CYCLES + 10) * 40);
        $display("timeout: the runs did not finish within %0d cycles", RUN_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule
